// ==== logic/pkt_pkg.sv ====
// ---------------------------------------------------------------------
// Memory response packet as seen by the engine setup path
// Offsets count 32-bit words and are not shifted
// ---------------------------------------------------------------------
`default_nettype none

package pkt_pkg;

    // -----------------------------------------------------------------
    // Widths
    // -----------------------------------------------------------------
    localparam int data_w   = 32;
    localparam int offset_w = 16;
    localparam int class_w  = 3;

    // -----------------------------------------------------------------
    // Buffer classes carried by a response word
    // -----------------------------------------------------------------
    typedef enum logic [class_w-1:0] {
        invalid      = 3'd0,
        cu_setup     = 3'd1,
        engine_setup = 3'd2,
        edges        = 3'd3,
        vertices     = 3'd4
    } buffer_class_t;

    // One response word, 52 bits wide
    typedef struct packed {
        logic                valid;
        buffer_class_t       buf_class;
        logic [offset_w-1:0] offset;
        logic [data_w-1:0]   data;
    } mem_packet_t;

endpackage : pkt_pkg

`default_nettype wire

// ==== logic/cfg_pkg.sv ====
// ---------------------------------------------------------------------
// Engine read/write configuration record and the setup word views
// One record is built from a 16-word window of setup words
// ---------------------------------------------------------------------
`default_nettype none

package cfg_pkg;

    // -----------------------------------------------------------------
    // Window and FIFO sizing
    // -----------------------------------------------------------------
    localparam int seq_words   = 16;
    localparam int index_w     = $clog2(seq_words);
    localparam int fifo_depth  = 16;
    localparam int prog_margin = 4;
    localparam int id_buffer_w = 4;

    // -----------------------------------------------------------------
    // Setup word views
    // -----------------------------------------------------------------
    // Word 0, mode and counting flags in the low bits
    typedef struct packed {
        logic [26:0] reserved;
        logic        mode_counter;
        logic        mode_buffer;
        logic        mode_sequence;
        logic        decrement;
        logic        increment;
    } flags_t;

    // Word 4, direction on top of a 31-bit granularity
    typedef struct packed {
        logic        direction;
        logic [30:0] granularity;
    } step_t;

    // Word 5, command and destination of the transfer
    typedef struct packed {
        logic [22:0]           reserved;
        logic [1:0]            id_engine;
        logic [1:0]            id_module;
        pkt_pkg::buffer_class_t buffer;
        logic [1:0]            cmd;
    } target_t;

    typedef union packed {
        logic [pkt_pkg::data_w-1:0] raw;
        flags_t                     flags;
        step_t                      step;
        target_t                    target;
    } setup_word_u;

    // Word FIFO entry, word plus its position in the window
    typedef struct packed {
        setup_word_u        word;
        logic [index_w-1:0] index;
    } setup_entry_t;

    // -----------------------------------------------------------------
    // Configuration record handed to the engine
    // -----------------------------------------------------------------
    typedef struct packed {
        flags_t                     flags;
        logic [pkt_pkg::data_w-1:0] index_start;
        logic [pkt_pkg::data_w-1:0] index_end;
        logic [pkt_pkg::data_w-1:0] stride;
        step_t                      step;
        target_t                    target;
        logic [id_buffer_w-1:0]     id_buffer;
        logic [pkt_pkg::data_w-1:0] array_size;
        logic [pkt_pkg::data_w-1:0] const_value;
    } rw_config_t;

endpackage : cfg_pkg

`default_nettype wire

// ==== logic/sync_fifo.sv ====
// ---------------------------------------------------------------------
// First-word-fall-through FIFO, head is valid while not_empty is high
// A push into a full FIFO is dropped unless a pop frees a slot
// nearly_full rises once free entries drop to margin
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  depth  = 16,
    parameter int  margin = 4
) (
    input  logic  ap_clk,
    input  logic  rst,
    input  logic  push,
    input  item_t push_data,
    input  logic  pop,
    output item_t head,
    output logic  not_empty,
    output logic  nearly_full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    item_t            mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_pop  = pop & not_empty;
    // Full FIFO still takes a word when the head leaves in the same cycle
    assign do_push = push & ((count != cnt_w'(depth)) | do_pop);

    // -----------------------------------------------------------------
    // Storage
    // -----------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // -----------------------------------------------------------------
    // Pointers and occupancy
    // -----------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head falls through as soon as it is written
    assign head        = mem[rd_ptr];
    assign not_empty   = (count != '0);
    assign nearly_full = (count >= cnt_w'(depth - margin));

endmodule : sync_fifo

`default_nettype wire

// ==== logic/setup_filter.sv ====
// ---------------------------------------------------------------------
// Keeps cu_setup and engine_setup words inside this engine's window
// Window starts at engine_slot * seq_words, offsets are word offsets
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module setup_filter #(
    parameter int engine_slot = 0
) (
    input  logic                          ap_clk,
    input  logic                          rst,
    input  pkt_pkg::mem_packet_t          pkt_in,
    output logic                          word_push,
    output cfg_pkg::setup_word_u          word_data,
    output logic [cfg_pkg::index_w-1:0]   word_index
);

    pkt_pkg::mem_packet_t         pkt_reg;
    logic [pkt_pkg::offset_w-1:0] rel_offset;
    logic                         class_ok;
    logic                         in_window;

    // Input stage, only the valid bit is cleared
    always_ff @(posedge ap_clk) begin
        pkt_reg <= pkt_in;
        if (rst) begin
            pkt_reg.valid <= 1'b0;
        end
    end

    // Offsets below the window wrap to large values and fail the bound
    assign rel_offset = pkt_reg.offset
                      - pkt_pkg::offset_w'(engine_slot * cfg_pkg::seq_words);
    assign in_window  = (rel_offset < pkt_pkg::offset_w'(cfg_pkg::seq_words));
    assign class_ok   = (pkt_reg.buf_class == pkt_pkg::cu_setup)
                      | (pkt_reg.buf_class == pkt_pkg::engine_setup);

    assign word_push  = pkt_reg.valid & class_ok & in_window;
    assign word_data  = cfg_pkg::setup_word_u'(pkt_reg.data);
    assign word_index = rel_offset[cfg_pkg::index_w-1:0];

endmodule : setup_filter

`default_nettype wire

// ==== logic/setup_collector.sv ====
// ---------------------------------------------------------------------
// Builds one configuration record from a 16-word setup window
// Words are taken by arrival order once index 0 opens the window
// Words 8 and 10 to 15 are consumed without effect
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module setup_collector (
    input  logic                        ap_clk,
    input  logic                        rst,
    input  logic                        word_valid,
    input  cfg_pkg::setup_word_u        word_data,
    input  logic [cfg_pkg::index_w-1:0] word_index,
    input  logic                        rec_space,
    output logic                        word_pop,
    output logic                        rec_push,
    output cfg_pkg::rw_config_t         rec_data
);

    // One-hot window position, all zero while idle
    logic [cfg_pkg::seq_words-1:0] pos;
    logic [cfg_pkg::seq_words-1:0] next_pos;
    logic                          idle;
    logic                          take;
    cfg_pkg::rw_config_t           rec_reg;

    // -----------------------------------------------------------------
    // Pop control
    // -----------------------------------------------------------------
    assign idle     = ~|pos;
    // Hold off while a record is being pushed or the record FIFO fills
    assign word_pop = word_valid & ~rec_push & rec_space;

    // Position the popped word will occupy
    assign next_pos = idle ? {{(cfg_pkg::seq_words-1){1'b0}}, 1'b1} : (pos << 1);

    // Idle words other than index 0 are popped and dropped
    assign take = word_pop & (~idle | (word_index == '0));

    always_ff @(posedge ap_clk) begin
        if (rst) begin
            pos      <= '0;
            rec_push <= 1'b0;
        end else begin
            // Last word of the window triggers a single push
            rec_push <= take & next_pos[cfg_pkg::seq_words-1];
            if (rec_push) begin
                pos <= '0;
            end else if (take) begin
                pos <= next_pos;
            end
        end
    end

    // -----------------------------------------------------------------
    // Field decode by window position
    // -----------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (take) begin
            case (1'b1)
                next_pos[0]: begin
                    rec_reg.flags.reserved      <= '0;
                    rec_reg.flags.mode_counter  <= word_data.flags.mode_counter;
                    rec_reg.flags.mode_buffer   <= word_data.flags.mode_buffer;
                    rec_reg.flags.mode_sequence <= word_data.flags.mode_sequence;
                    rec_reg.flags.decrement     <= word_data.flags.decrement;
                    rec_reg.flags.increment     <= word_data.flags.increment;
                end
                next_pos[1]: begin
                    rec_reg.index_start <= word_data.raw;
                end
                next_pos[2]: begin
                    rec_reg.index_end <= word_data.raw;
                end
                next_pos[3]: begin
                    rec_reg.stride <= word_data.raw;
                end
                next_pos[4]: begin
                    rec_reg.step.direction   <= word_data.step.direction;
                    rec_reg.step.granularity <= word_data.step.granularity;
                end
                next_pos[5]: begin
                    // Destination fields only, upper bits are not carried
                    rec_reg.target.reserved  <= '0;
                    rec_reg.target.id_engine <= word_data.target.id_engine;
                    rec_reg.target.id_module <= word_data.target.id_module;
                    rec_reg.target.buffer    <= word_data.target.buffer;
                    rec_reg.target.cmd       <= word_data.target.cmd;
                end
                next_pos[6]: begin
                    rec_reg.id_buffer <= word_data.raw[cfg_pkg::id_buffer_w-1:0];
                end
                next_pos[7]: begin
                    rec_reg.array_size <= word_data.raw;
                end
                next_pos[9]: begin
                    rec_reg.const_value <= word_data.raw;
                end
                default: begin
                    rec_reg <= rec_reg;
                end
            endcase
        end
    end

    // Stable during rec_push since no word is popped then
    assign rec_data = rec_reg;

endmodule : setup_collector

`default_nettype wire

// ==== logic/config_loader_top.sv ====
// ---------------------------------------------------------------------
// Setup loader for one engine, filter to word FIFO to collector
// Source must send only while pkt_ready is high
// cfg_out and cfg_valid hold until taken with cfg_ready
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module config_loader_top #(
    parameter int engine_slot = 0
) (
    input  logic                 ap_clk,
    input  logic                 rst,
    input  pkt_pkg::mem_packet_t pkt_in,
    output logic                 pkt_ready,
    output cfg_pkg::rw_config_t  cfg_out,
    output logic                 cfg_valid,
    input  logic                 cfg_ready
);

    cfg_pkg::setup_entry_t word_in;
    cfg_pkg::setup_entry_t word_head;
    logic                  word_push;
    logic                  word_pop;
    logic                  word_not_empty;
    logic                  word_nearly_full;
    cfg_pkg::rw_config_t   rec_data;
    logic                  rec_push;
    logic                  rec_nearly_full;

    // -----------------------------------------------------------------
    // Input filter and word FIFO
    // -----------------------------------------------------------------
    setup_filter #(
        .engine_slot(engine_slot)
    ) setup_filter_inst (
        .ap_clk    (ap_clk),
        .rst       (rst),
        .pkt_in    (pkt_in),
        .word_push (word_push),
        .word_data (word_in.word),
        .word_index(word_in.index)
    );

    sync_fifo #(
        .item_t(cfg_pkg::setup_entry_t),
        .depth (cfg_pkg::fifo_depth),
        .margin(cfg_pkg::prog_margin)
    ) word_fifo_inst (
        .ap_clk     (ap_clk),
        .rst        (rst),
        .push       (word_push),
        .push_data  (word_in),
        .pop        (word_pop),
        .head       (word_head),
        .not_empty  (word_not_empty),
        .nearly_full(word_nearly_full)
    );

    // Margin covers words already inside the filter register
    assign pkt_ready = ~word_nearly_full;

    // -----------------------------------------------------------------
    // Collector and record FIFO
    // -----------------------------------------------------------------
    setup_collector setup_collector_inst (
        .ap_clk    (ap_clk),
        .rst       (rst),
        .word_valid(word_not_empty),
        .word_data (word_head.word),
        .word_index(word_head.index),
        .rec_space (~rec_nearly_full),
        .word_pop  (word_pop),
        .rec_push  (rec_push),
        .rec_data  (rec_data)
    );

    sync_fifo #(
        .item_t(cfg_pkg::rw_config_t),
        .depth (cfg_pkg::fifo_depth),
        .margin(cfg_pkg::prog_margin)
    ) rec_fifo_inst (
        .ap_clk     (ap_clk),
        .rst        (rst),
        .push       (rec_push),
        .push_data  (rec_data),
        .pop        (cfg_valid & cfg_ready),
        .head       (cfg_out),
        .not_empty  (cfg_valid),
        .nearly_full(rec_nearly_full)
    );

endmodule : config_loader_top

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
// ----------------------------------------------------------------------
// Clock and reset for the loader testbench
// 40 ns period, reset held high for the first 16 rising edges
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic ap_clk,
    output logic rst
);

    initial begin
        ap_clk = 1'b0;
        forever #20 ap_clk = ~ap_clk;
    end

    // Released on a falling edge, like every other DUT input
    initial begin
        rst = 1'b1;
        repeat (16) @(negedge ap_clk);
        rst <= 1'b0;
    end

endmodule : tb_clock_gen

`default_nettype wire

// ==== test/config_loader_tb.sv ====
// ----------------------------------------------------------------------
// Table-driven testbench for the engine setup loader, engine slot 2
// Stimulus rows drive pkt_in and cfg_ready on falling edges
// Expected records come from a positional model of the setup window
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module config_loader_tb;

    localparam int engine_slot = 2;
    localparam int window_base = engine_slot * cfg_pkg::seq_words;
    localparam int drain_limit = 2000;

    // One stimulus row of the table
    typedef struct packed {
        logic                          valid;
        pkt_pkg::buffer_class_t        cls;
        logic [pkt_pkg::offset_w-1:0]  offset;
        logic [pkt_pkg::data_w-1:0]    data;
        logic                          ready;
    } stim_row_t;

    logic                 ap_clk;
    logic                 rst;
    pkt_pkg::mem_packet_t pkt_in;
    logic                 pkt_ready;
    cfg_pkg::rw_config_t  cfg_out;
    logic                 cfg_valid;
    logic                 cfg_ready;

    stim_row_t            stim[$];
    cfg_pkg::rw_config_t  exp_q[$];
    logic [31:0]          model_words[cfg_pkg::seq_words];
    bit                   model_active;
    int                   model_pos;
    bit                   table_built;
    bit                   saw_ready_low;
    int                   watchdog_cycles;
    int                   rec_n;

    tb_clock_gen tb_clock_gen_inst (
        .ap_clk(ap_clk),
        .rst   (rst)
    );

    config_loader_top #(
        .engine_slot(engine_slot)
    ) config_loader_top_inst (
        .ap_clk   (ap_clk),
        .rst      (rst),
        .pkt_in   (pkt_in),
        .pkt_ready(pkt_ready),
        .cfg_out  (cfg_out),
        .cfg_valid(cfg_valid),
        .cfg_ready(cfg_ready)
    );

    // ------------------------------------------------------------------
    // Checking helpers
    // ------------------------------------------------------------------
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s mismatch, got %08h expected %08h",
                     $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("Run stopped: %s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    // ------------------------------------------------------------------
    // Table building
    // ------------------------------------------------------------------
    task automatic add_row(input logic valid, input pkt_pkg::buffer_class_t cls,
                           input int offset, input logic [31:0] data,
                           input logic ready);
        stim_row_t row;
        row.valid  = valid;
        row.cls    = cls;
        row.offset = pkt_pkg::offset_w'(offset);
        row.data   = data;
        row.ready  = ready;
        stim.push_back(row);
    endtask

    task automatic add_idle(input int n, input logic ready);
        for (int i = 0; i < n; i++) begin
            add_row(1'b0, pkt_pkg::invalid, 0, $urandom, ready);
        end
    endtask

    // Consumer is ready from word ready_from on, junk rows are foreign words
    task automatic add_window(input pkt_pkg::buffer_class_t cls, input int ready_from,
                              input bit junk);
        logic rdy;
        for (int i = 0; i < cfg_pkg::seq_words; i++) begin
            rdy = (i >= ready_from);
            add_row(1'b1, cls, window_base + i, $urandom, rdy);
            if (junk) begin
                case (i)
                    2:  add_row(1'b1, pkt_pkg::edges, window_base + 3, $urandom, rdy);
                    6:  add_row(1'b1, pkt_pkg::engine_setup, 16, $urandom, rdy);
                    10: add_row(1'b1, pkt_pkg::cu_setup, 48, $urandom, rdy);
                    12: add_row(1'b1, pkt_pkg::vertices, window_base + 1, $urandom, rdy);
                    14: add_row(1'b0, pkt_pkg::engine_setup, window_base, $urandom, rdy);
                    default: ;
                endcase
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Reference model of filter and window decode
    // ------------------------------------------------------------------
    function automatic cfg_pkg::rw_config_t build_expected();
        cfg_pkg::rw_config_t rec;
        rec.flags       = cfg_pkg::flags_t'({27'd0, model_words[0][4:0]});
        rec.index_start = model_words[1];
        rec.index_end   = model_words[2];
        rec.stride      = model_words[3];
        rec.step        = cfg_pkg::step_t'(model_words[4]);
        rec.target      = cfg_pkg::target_t'({23'd0, model_words[5][8:0]});
        rec.id_buffer   = model_words[6][3:0];
        rec.array_size  = model_words[7];
        rec.const_value = model_words[9];
        return rec;
    endfunction

    task automatic model_accept(input stim_row_t row);
        int idx;
        idx = int'(row.offset) - window_base;
        if ((row.cls == pkt_pkg::cu_setup || row.cls == pkt_pkg::engine_setup)
                && idx >= 0 && idx < cfg_pkg::seq_words) begin
            // Only index 0 opens a window, later words go by position
            if (!model_active && idx == 0) begin
                model_active = 1'b1;
                model_pos    = 0;
            end
            if (model_active) begin
                model_words[model_pos] = row.data;
                model_pos++;
                if (model_pos == cfg_pkg::seq_words) begin
                    exp_q.push_back(build_expected());
                    model_active = 1'b0;
                end
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Output monitor, samples on the transfer edge
    // ------------------------------------------------------------------
    always @(posedge ap_clk) begin
        cfg_pkg::rw_config_t exp;
        if (!rst && !pkt_ready) begin
            saw_ready_low = 1'b1;
        end
        if (!rst && cfg_valid && cfg_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("a record came out that no window produced");
            end else begin
                exp = exp_q.pop_front();
                check_value($sformatf("record %0d flags", rec_n), cfg_out.flags, exp.flags);
                check_value($sformatf("record %0d index_start", rec_n),
                            cfg_out.index_start, exp.index_start);
                check_value($sformatf("record %0d index_end", rec_n),
                            cfg_out.index_end, exp.index_end);
                check_value($sformatf("record %0d stride", rec_n),
                            cfg_out.stride, exp.stride);
                check_value($sformatf("record %0d step", rec_n), cfg_out.step, exp.step);
                check_value($sformatf("record %0d target", rec_n),
                            cfg_out.target, exp.target);
                check_value($sformatf("record %0d id_buffer", rec_n),
                            {28'd0, cfg_out.id_buffer}, {28'd0, exp.id_buffer});
                check_value($sformatf("record %0d array_size", rec_n),
                            cfg_out.array_size, exp.array_size);
                check_value($sformatf("record %0d const_value", rec_n),
                            cfg_out.const_value, exp.const_value);
                rec_n++;
            end
        end
    end

    // Watchdog, sized from the table once it exists
    initial begin
        wait (table_built);
        repeat (watchdog_cycles) @(posedge ap_clk);
        $display("Watchdog expired after %0d cycles without the run finishing",
                 watchdog_cycles);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog timeout");
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        stim_row_t row;
        int        wait_n;
        pkt_in        = '0;
        cfg_ready     = 1'b0;
        model_active  = 1'b0;
        model_pos     = 0;
        saw_ready_low = 1'b0;
        rec_n         = 0;
        table_built   = 1'b0;
        void'($urandom(32'h794a960f));

        // Single in-order window
        add_window(pkt_pkg::engine_setup, 0, 1'b0);
        add_idle(4, 1'b1);
        // Window with foreign classes and offsets mixed in
        add_window(pkt_pkg::engine_setup, 0, 1'b1);
        add_idle(4, 1'b1);
        // Back-to-back cu_setup and engine_setup windows
        add_window(pkt_pkg::cu_setup, 0, 1'b0);
        add_window(pkt_pkg::engine_setup, 0, 1'b0);
        add_idle(10, 1'b1);
        // Record FIFO fills after 12 windows, two spare rows keep the collector level
        for (int w = 0; w < 12; w++) begin
            add_window(pkt_pkg::engine_setup, 16, 1'b0);
            add_idle(2, 1'b0);
        end
        // Word FIFO reaches nearly full before word 14, consumer wakes there
        add_window(pkt_pkg::engine_setup, 13, 1'b0);
        add_window(pkt_pkg::cu_setup, 0, 1'b0);
        add_idle(20, 1'b1);

        watchdog_cycles = stim.size() * 40 + 500;
        table_built     = 1'b1;

        // Reset is high by the first falling edge
        @(negedge ap_clk);
        while (rst) @(negedge ap_clk);
        check_value("cfg_valid after reset", 32'(cfg_valid), 32'd0);
        check_value("pkt_ready after reset", 32'(pkt_ready), 32'd1);

        for (int r = 0; r < stim.size(); r++) begin
            row = stim[r];
            @(negedge ap_clk);
            cfg_ready    = row.ready;
            pkt_in.valid = 1'b0;
            if (row.valid) begin
                while (!pkt_ready) @(negedge ap_clk);
            end
            pkt_in.valid     = row.valid;
            pkt_in.buf_class = row.cls;
            pkt_in.offset    = row.offset;
            pkt_in.data      = row.data;
            if (row.valid) begin
                model_accept(row);
            end
        end
        @(negedge ap_clk);
        pkt_in.valid = 1'b0;
        cfg_ready    = 1'b1;

        for (wait_n = 0; wait_n < drain_limit && exp_q.size() != 0; wait_n++) begin
            @(negedge ap_clk);
        end
        check_value("pkt_ready fell under back-pressure", 32'(saw_ready_low), 32'd1);

        if (exp_q.size() != 0) begin
            $display("Run stopped: %0d expected records never came out", exp_q.size());
            $display("STATUS: FAIL");
            $fatal(1, "records missing");
        end else begin
            $display("%0d records checked", rec_n);
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule : config_loader_tb

`default_nettype wire

// ==== sources.f ====
logic/pkt_pkg.sv
logic/cfg_pkg.sv
logic/sync_fifo.sv
logic/setup_filter.sv
logic/setup_collector.sv
logic/config_loader_top.sv
test/tb_clock_gen.sv
test/config_loader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the loader testbench with Verilator and runs it.
# Exit status is non-zero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module config_loader_tb \
    -f sources.f \
    -o config_loader_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/config_loader_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

exit 0
